// File: mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

    // ========================================
    // Processor side widths and constants
    // ========================================

    // Instruction memory word, also the receive data width.
    typedef logic [31:0] instr_t;

    // Halt marks the end of a loaded program.
    localparam instr_t HALT_INSTR = 32'hFFFF_FFFF;

    // Cycle field carried in a report word.
    localparam int REPORT_CYCLE_BITS = 16;

    typedef logic [REPORT_CYCLE_BITS-1:0] report_cycles_t;

endpackage

`default_nettype wire

// File: debug_proto_pkg.sv
`default_nettype none

package debug_proto_pkg;

    import mips_core_pkg::*;

    // ========================================
    // Commands from the host
    // ========================================

    typedef logic [7:0] cmd_byte_t;

    localparam cmd_byte_t CMD_LOAD    = "L";
    localparam cmd_byte_t CMD_FLUSH   = "F";
    localparam cmd_byte_t CMD_EXECUTE = "E";

    // ========================================
    // Reports to the host
    // ========================================

    typedef logic [7:0] report_kind_t;
    typedef logic [7:0] report_code_t;

    localparam report_kind_t REPORT_INFO  = "I";
    localparam report_kind_t REPORT_ERROR = "E";

    localparam report_code_t CODE_UNKNOWN_CMD = 8'd1;
    localparam report_code_t CODE_NO_PROGRAM  = 8'd2;
    localparam report_code_t CODE_MEMORY_FULL = 8'd3;
    localparam report_code_t CODE_LOAD_DONE   = 8'd4;
    localparam report_code_t CODE_END_PROGRAM = 8'd5;

    typedef enum logic [2:0] {
        REP_UNKNOWN_CMD,
        REP_NO_PROGRAM,
        REP_MEMORY_FULL,
        REP_LOAD_DONE,
        REP_END_PROGRAM
    } report_sel_t;

    // Kind in the top byte, code in the bottom byte.
    typedef struct packed {
        report_kind_t   kind;
        report_cycles_t cycles;
        report_code_t   code;
    } report_word_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RD_WAIT,
        ST_DECODE,
        ST_FLUSH,
        ST_LOAD_IDLE,
        ST_LOAD,
        ST_RUN,
        ST_REPORT,
        ST_WR_WAIT
    } seq_state_t;

endpackage

`default_nettype wire

// File: cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_counter
#(
    parameter int CYCLE_WIDTH = 32
)
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_clear,
    input  logic                   i_mips_enabled,
    input  logic                   i_mips_end_program,
    output logic [CYCLE_WIDTH-1:0] o_count
);

    // Count only cycles the core actually executes.
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_count <= '0;
        end
        else if (i_clear)
        begin
            o_count <= '0;
        end
        else if (i_mips_enabled && !i_mips_end_program)
        begin
            o_count <= o_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: instruction_loader.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_loader
    import mips_core_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_capture,
    input  instr_t i_rd_data,
    output instr_t o_instruction,
    output logic   o_instr_wr,
    output logic   o_halt_seen
);

    instr_t instr_q;
    logic   instr_wr_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            instr_q    <= '0;
            instr_wr_q <= 1'b0;
        end
        else
        begin
            instr_wr_q <= i_capture;
            if (i_capture)
            begin
                instr_q <= i_rd_data;
            end
            else if (o_halt_seen)
            begin
                // Drop the halt once the sequencer has seen it.
                instr_q <= '0;
            end
        end
    end

    assign o_instruction = instr_q;
    assign o_instr_wr    = instr_wr_q;
    assign o_halt_seen   = (instr_q == HALT_INSTR);

endmodule

`default_nettype wire

// File: report_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module report_formatter
    import mips_core_pkg::*;
    import debug_proto_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_load,
    input  report_sel_t    i_sel,
    input  report_cycles_t i_cycles,
    output report_word_t   o_report
);

    report_word_t report_next;

    always_comb
    begin
        report_next = '0;
        case (i_sel)
            REP_UNKNOWN_CMD:
            begin
                report_next.kind = REPORT_ERROR;
                report_next.code = CODE_UNKNOWN_CMD;
            end
            REP_NO_PROGRAM:
            begin
                report_next.kind = REPORT_ERROR;
                report_next.code = CODE_NO_PROGRAM;
            end
            REP_MEMORY_FULL:
            begin
                report_next.kind = REPORT_ERROR;
                report_next.code = CODE_MEMORY_FULL;
            end
            REP_LOAD_DONE:
            begin
                report_next.kind = REPORT_INFO;
                report_next.code = CODE_LOAD_DONE;
            end
            REP_END_PROGRAM:
            begin
                // Only this report carries the cycle count.
                report_next.kind   = REPORT_INFO;
                report_next.cycles = i_cycles;
                report_next.code   = CODE_END_PROGRAM;
            end
            default:
            begin
                report_next = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_report <= '0;
        else if (i_load)
            o_report <= report_next;
    end

endmodule

`default_nettype wire

// File: debug_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module debug_sequencer
    import debug_proto_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_rd_end,
    input  logic        i_wr_end,
    input  logic        i_imem_empty,
    input  logic        i_imem_full,
    input  logic        i_mips_end_program,
    input  logic        i_halt_seen,
    input  cmd_byte_t   i_cmd,
    output logic        o_rd_start,
    output logic        o_wr_start,
    output logic        o_mips_flush,
    output logic        o_mips_clear_program,
    output logic        o_mips_enabled,
    output logic        o_load_capture,
    output logic        o_report_load,
    output logic        o_count_clear,
    output report_sel_t o_report_sel
);

    seq_state_t state, state_next;
    seq_state_t return_state, return_state_next;
    logic       rd_start, rd_start_next;
    logic       wr_start, wr_start_next;
    logic       flush, flush_next;
    logic       clear_program, clear_program_next;
    logic       enabled, enabled_next;
    logic       count_clear, count_clear_next;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state         <= ST_IDLE;
            return_state  <= ST_IDLE;
            rd_start      <= 1'b0;
            wr_start      <= 1'b0;
            flush         <= 1'b0;
            clear_program <= 1'b0;
            enabled       <= 1'b0;
            count_clear   <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            return_state  <= return_state_next;
            rd_start      <= rd_start_next;
            wr_start      <= wr_start_next;
            flush         <= flush_next;
            clear_program <= clear_program_next;
            enabled       <= enabled_next;
            count_clear   <= count_clear_next;
        end
    end

    always_comb
    begin
        state_next         = state;
        return_state_next  = return_state;
        rd_start_next      = rd_start;
        wr_start_next      = wr_start;
        flush_next         = flush;
        clear_program_next = clear_program;
        enabled_next       = enabled;
        count_clear_next   = count_clear;
        o_report_load      = 1'b0;
        o_report_sel       = REP_UNKNOWN_CMD;

        case (state)
            // ========================================
            // Serial handshakes
            // ========================================
            ST_IDLE:
            begin
                rd_start_next     = 1'b1;
                return_state_next = ST_DECODE;
                state_next        = ST_RD_WAIT;
            end

            ST_RD_WAIT:
            begin
                rd_start_next = 1'b0;
                // End level may be stale while the start pulse is out.
                if (i_rd_end && !rd_start)
                    state_next = return_state;
            end

            ST_REPORT:
            begin
                wr_start_next = 1'b1;
                state_next    = ST_WR_WAIT;
            end

            ST_WR_WAIT:
            begin
                wr_start_next = 1'b0;
                if (i_wr_end && !wr_start)
                    state_next = return_state;
            end

            // ========================================
            // Command decode
            // ========================================
            ST_DECODE:
            begin
                case (i_cmd)
                    CMD_LOAD:
                    begin
                        flush_next         = 1'b1;
                        clear_program_next = 1'b1;
                        return_state_next  = ST_LOAD_IDLE;
                        state_next         = ST_FLUSH;
                    end
                    CMD_FLUSH:
                    begin
                        flush_next         = 1'b1;
                        clear_program_next = 1'b1;
                        return_state_next  = ST_IDLE;
                        state_next         = ST_FLUSH;
                    end
                    CMD_EXECUTE:
                    begin
                        flush_next        = 1'b1;
                        count_clear_next  = 1'b1;
                        return_state_next = ST_RUN;
                        state_next        = ST_FLUSH;
                    end
                    default:
                    begin
                        o_report_load     = 1'b1;
                        o_report_sel      = REP_UNKNOWN_CMD;
                        return_state_next = ST_IDLE;
                        state_next        = ST_REPORT;
                    end
                endcase
            end

            ST_FLUSH:
            begin
                flush_next         = 1'b0;
                clear_program_next = 1'b0;
                count_clear_next   = 1'b0;
                state_next         = return_state;
            end

            // ========================================
            // Program load
            // ========================================
            ST_LOAD_IDLE:
            begin
                if (i_halt_seen)
                begin
                    o_report_load     = 1'b1;
                    o_report_sel      = REP_LOAD_DONE;
                    return_state_next = ST_IDLE;
                    state_next        = ST_REPORT;
                end
                else if (i_imem_full)
                begin
                    o_report_load     = 1'b1;
                    o_report_sel      = REP_MEMORY_FULL;
                    return_state_next = ST_IDLE;
                    state_next        = ST_REPORT;
                end
                else
                begin
                    rd_start_next     = 1'b1;
                    return_state_next = ST_LOAD;
                    state_next        = ST_RD_WAIT;
                end
            end

            // Word goes to the loader this cycle.
            ST_LOAD:
            begin
                state_next = ST_LOAD_IDLE;
            end

            // ========================================
            // Continuous run
            // ========================================
            ST_RUN:
            begin
                if (!enabled)
                begin
                    if (i_imem_empty)
                    begin
                        o_report_load     = 1'b1;
                        o_report_sel      = REP_NO_PROGRAM;
                        return_state_next = ST_IDLE;
                        state_next        = ST_REPORT;
                    end
                    else
                    begin
                        enabled_next = 1'b1;
                    end
                end
                else if (i_mips_end_program)
                begin
                    enabled_next      = 1'b0;
                    o_report_load     = 1'b1;
                    o_report_sel      = REP_END_PROGRAM;
                    return_state_next = ST_IDLE;
                    state_next        = ST_REPORT;
                end
            end

            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign o_rd_start           = rd_start;
    assign o_wr_start           = wr_start;
    assign o_mips_flush         = flush;
    assign o_mips_clear_program = clear_program;
    assign o_mips_enabled       = enabled;
    assign o_count_clear        = count_clear;
    assign o_load_capture       = (state == ST_LOAD);

endmodule

`default_nettype wire

// File: debugger_control.sv
`timescale 1ns/1ps
`default_nettype none

module debugger_control
    import mips_core_pkg::*;
    import debug_proto_pkg::*;
#(
    parameter int CYCLE_WIDTH = 32
)
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rd_end,
    input  logic                   i_wr_end,
    input  logic                   i_imem_empty,
    input  logic                   i_imem_full,
    input  logic                   i_mips_end_program,
    input  instr_t                 i_rd_data,
    output logic                   o_rd_start,
    output logic                   o_wr_start,
    output logic                   o_mips_flush,
    output logic                   o_mips_clear_program,
    output logic                   o_mips_enabled,
    output logic                   o_instr_wr,
    output report_word_t           o_wr_data,
    output instr_t                 o_instruction,
    output logic [CYCLE_WIDTH-1:0] o_cycle_count
);

    logic        halt_seen;
    logic        load_capture;
    logic        report_load;
    logic        count_clear;
    report_sel_t report_sel;

    debug_sequencer u_sequencer (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_rd_end             (i_rd_end),
        .i_wr_end             (i_wr_end),
        .i_imem_empty         (i_imem_empty),
        .i_imem_full          (i_imem_full),
        .i_mips_end_program   (i_mips_end_program),
        .i_halt_seen          (halt_seen),
        .i_cmd                (i_rd_data[7:0]),
        .o_rd_start           (o_rd_start),
        .o_wr_start           (o_wr_start),
        .o_mips_flush         (o_mips_flush),
        .o_mips_clear_program (o_mips_clear_program),
        .o_mips_enabled       (o_mips_enabled),
        .o_load_capture       (load_capture),
        .o_report_load        (report_load),
        .o_count_clear        (count_clear),
        .o_report_sel         (report_sel)
    );

    cycle_counter #(
        .CYCLE_WIDTH (CYCLE_WIDTH)
    ) u_counter (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_clear            (count_clear),
        .i_mips_enabled     (o_mips_enabled),
        .i_mips_end_program (i_mips_end_program),
        .o_count            (o_cycle_count)
    );

    instruction_loader u_loader (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_capture     (load_capture),
        .i_rd_data     (i_rd_data),
        .o_instruction (o_instruction),
        .o_instr_wr    (o_instr_wr),
        .o_halt_seen   (halt_seen)
    );

    // Report carries only the low part of the count.
    report_formatter u_formatter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_load   (report_load),
        .i_sel    (report_sel),
        .i_cycles (o_cycle_count[REPORT_CYCLE_BITS-1:0]),
        .o_report (o_wr_data)
    );

endmodule

`default_nettype wire

// File: debugger_control_checker.sv
`timescale 1ns/1ps
`default_nettype none

module debugger_control_checker
    import mips_core_pkg::*;
    import debug_proto_pkg::*;
#(
    parameter int CYCLE_WIDTH = 32
)
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_rd_start,
    input  logic                   i_wr_start,
    input  logic                   i_mips_flush,
    input  logic                   i_mips_clear_program,
    input  logic                   i_mips_enabled,
    input  logic                   i_instr_wr,
    input  report_word_t           i_wr_data,
    input  instr_t                 i_instruction,
    input  logic [CYCLE_WIDTH-1:0] i_cycle_count
);

    // One sticky flag per property.
    logic overlap_seen = 1'b0;
    logic flush_long_seen = 1'b0;
    logic wr_long_seen = 1'b0;
    logic enable_busy_seen = 1'b0;
    logic enable_rise_seen = 1'b0;
    logic reset_seen = 1'b0;
    logic any_failed;

    assign any_failed = overlap_seen | flush_long_seen | wr_long_seen
                      | enable_busy_seen | enable_rise_seen | reset_seen;

    // ========================================
    // Handshake and pulse rules
    // ========================================

    assert property (@(posedge i_clk) !(i_rd_start && i_wr_start))
    else
    begin
        $error("Read and write start pulses overlap.");
        overlap_seen = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (i_reset) i_mips_flush |=> !i_mips_flush)
    else
    begin
        $error("Flush pulse longer than one cycle.");
        flush_long_seen = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (i_reset) i_instr_wr |=> !i_instr_wr)
    else
    begin
        $error("Instruction write strobe longer than one cycle.");
        wr_long_seen = 1'b1;
    end

    // Core runs only while nothing else is going on.
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_mips_enabled |-> !(i_rd_start || i_wr_start || i_mips_flush || i_instr_wr))
    else
    begin
        $error("Core enabled outside a run.");
        enable_busy_seen = 1'b1;
    end

    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_mips_enabled) |-> $past(i_mips_flush, 2))
    else
    begin
        $error("Core enabled without a flush two cycles before.");
        enable_rise_seen = 1'b1;
    end

    assert property (@(posedge i_clk)
        (i_reset && $past(i_reset)) |->
            (!(i_rd_start || i_wr_start || i_mips_flush || i_mips_clear_program
               || i_mips_enabled || i_instr_wr)
             && i_wr_data == '0 && i_instruction == '0 && i_cycle_count == '0))
    else
    begin
        $error("Outputs not quiet during reset.");
        reset_seen = 1'b1;
    end

endmodule

bind debugger_control debugger_control_checker #(
    .CYCLE_WIDTH (CYCLE_WIDTH)
) u_checker (
    .i_clk                (i_clk),
    .i_reset              (i_reset),
    .i_rd_start           (o_rd_start),
    .i_wr_start           (o_wr_start),
    .i_mips_flush         (o_mips_flush),
    .i_mips_clear_program (o_mips_clear_program),
    .i_mips_enabled       (o_mips_enabled),
    .i_instr_wr           (o_instr_wr),
    .i_wr_data            (o_wr_data),
    .i_instruction        (o_instruction),
    .i_cycle_count        (o_cycle_count)
);

`default_nettype wire

// File: tb_debugger_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debugger_control
    import mips_core_pkg::*;
    import debug_proto_pkg::*;
();

    typedef struct packed {
        cmd_byte_t      cmd;
        logic [2:0]     nwords;
        instr_t [3:0]   words;
        logic           empty;
        logic           full;
        report_cycles_t run_len;
        report_kind_t   kind;
        report_code_t   code;
    } test_vec_t;

    logic         i_clk;
    logic         i_reset;
    logic         i_rd_end;
    logic         i_wr_end;
    logic         i_imem_empty;
    logic         i_imem_full;
    logic         i_mips_end_program;
    instr_t       i_rd_data;
    logic         o_rd_start;
    logic         o_wr_start;
    logic         o_mips_flush;
    logic         o_mips_clear_program;
    logic         o_mips_enabled;
    logic         o_instr_wr;
    report_word_t o_wr_data;
    instr_t       o_instruction;
    logic [31:0]  o_cycle_count;

    test_vec_t    vecs[$];
    string        names[$];
    string        cur_name = "reset";
    instr_t       rx_queue[$];
    instr_t       exp_words[$];
    report_word_t wr_word;
    report_word_t wr_prev = '0;
    report_word_t last_report;
    logic [7:0]   lfsr = 8'd23;
    logic         rd_pending = 1'b0;
    logic         wr_pending = 1'b0;
    logic         enabled_prev = 1'b0;
    int           rd_delay, wr_delay, rd_end_cycle, flush_cycle, end_cycle;
    int           cycle = 0;
    int           cycle_limit = 1000;
    int           idle_starts = 0;
    int           flushes, clears, writes, reports, enabled_seen, run_len;

    debugger_control #(
        .CYCLE_WIDTH (32)
    ) dut (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_rd_end             (i_rd_end),
        .i_wr_end             (i_wr_end),
        .i_imem_empty         (i_imem_empty),
        .i_imem_full          (i_imem_full),
        .i_mips_end_program   (i_mips_end_program),
        .i_rd_data            (i_rd_data),
        .o_rd_start           (o_rd_start),
        .o_wr_start           (o_wr_start),
        .o_mips_flush         (o_mips_flush),
        .o_mips_clear_program (o_mips_clear_program),
        .o_mips_enabled       (o_mips_enabled),
        .o_instr_wr           (o_instr_wr),
        .o_wr_data            (o_wr_data),
        .o_instruction        (o_instruction),
        .o_cycle_count        (o_cycle_count)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ========================================
    // Error handling and random delays
    // ========================================

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH test %s: %s expected %h actual %h",
                     cur_name, what, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Two bits give a delay of 0 to 3 cycles.
    task automatic draw_delay(output int d);
        int i;
        d = 0;
        for (i = 0; i < 2; i++)
        begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
    endtask

    // ========================================
    // Serial and core models
    // ========================================

    task automatic serve_receiver();
        if (o_rd_start)
        begin
            if (rd_pending)
            begin
                $display("Read start issued while a read was still outstanding.");
                stop_run();
            end
            i_rd_end = 1'b0;
            rd_pending = 1'b1;
            draw_delay(rd_delay);
            if (rx_queue.size() == 0)
                idle_starts++;
        end
        else if (rd_pending)
        begin
            if (rd_delay > 0)
                rd_delay--;
            else if (rx_queue.size() > 0)
            begin
                i_rd_data = rx_queue.pop_front();
                i_rd_end = 1'b1;
                rd_pending = 1'b0;
                rd_end_cycle = cycle;
            end
        end
    endtask

    task automatic serve_transmitter();
        if (o_wr_start)
        begin
            if (wr_pending)
            begin
                $display("Write start issued while a write was still outstanding.");
                stop_run();
            end
            check_value("report before start", wr_prev, o_wr_data);
            i_wr_end = 1'b0;
            wr_pending = 1'b1;
            wr_word = o_wr_data;
            draw_delay(wr_delay);
        end
        else if (wr_pending)
        begin
            check_value("report held", wr_word, o_wr_data);
            if (wr_delay > 0)
                wr_delay--;
            else
            begin
                i_wr_end = 1'b1;
                wr_pending = 1'b0;
                last_report = wr_word;
                reports++;
            end
        end
        wr_prev = o_wr_data;
    endtask

    // End of program comes after run_len executed cycles.
    task automatic serve_core();
        if (o_mips_flush)
        begin
            i_mips_end_program = 1'b0;
            enabled_seen = 0;
        end
        else if (o_mips_enabled && !i_mips_end_program && enabled_seen == run_len)
        begin
            i_mips_end_program = 1'b1;
            end_cycle = cycle;
        end
        if (o_mips_enabled && !i_mips_end_program)
            enabled_seen++;
    endtask

    task automatic watch_outputs();
        if (o_mips_flush)
        begin
            flushes++;
            flush_cycle = cycle;
            if (o_mips_clear_program)
                clears++;
        end
        else if (o_mips_clear_program)
        begin
            $display("Clear-program raised without a flush in test %s.", cur_name);
            stop_run();
        end
        if (o_instr_wr)
        begin
            if (writes >= exp_words.size())
            begin
                $display("Instruction write with no word expected in test %s.", cur_name);
                stop_run();
            end
            check_value("instruction", exp_words[writes], o_instruction);
            check_value("write delay", 2, cycle - rd_end_cycle);
            writes++;
        end
        if (o_mips_enabled && !enabled_prev)
            check_value("enable delay", 2, cycle - flush_cycle);
        if (!o_mips_enabled && enabled_prev)
            check_value("enable fall", 1, cycle - end_cycle);
        enabled_prev = o_mips_enabled;
    endtask

    // Outputs are read and inputs driven 1 ns after the edge.
    task automatic step_cycle();
        @(posedge i_clk);
        #1;
        cycle++;
        if (cycle > cycle_limit)
        begin
            $display("Timeout in test %s after %0d cycles.", cur_name, cycle);
            stop_run();
        end
        if (dut.u_checker.any_failed)
        begin
            $display("An assertion in the bound checker failed.");
            stop_run();
        end
        serve_receiver();
        serve_transmitter();
        serve_core();
        watch_outputs();
    endtask

    // ========================================
    // Test file and result checks
    // ========================================

    task automatic read_tests();
        int          fd, n, nw, em, fu, rl;
        string       line, nm;
        logic [31:0] c, w0, w1, w2, w3, k, cd;
        test_vec_t   v;
        fd = $fopen("debugger_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the test file debugger_tests.txt.");
            stop_run();
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%s %h %d %h %h %h %h %d %d %d %h %h",
                        nm, c, nw, w0, w1, w2, w3, em, fu, rl, k, cd);
            if (n != 12)
            begin
                $display("Malformed line in the test file: %s", line);
                stop_run();
            end
            v.cmd = c[7:0];
            v.nwords = nw[2:0];
            v.words = {w3, w2, w1, w0};
            v.empty = em[0];
            v.full = fu[0];
            v.run_len = rl[15:0];
            v.kind = k[7:0];
            v.code = cd[7:0];
            vecs.push_back(v);
            names.push_back(nm);
        end
        $fclose(fd);
    endtask

    task automatic check_results(input test_vec_t v);
        int is_cmd, exp_clear, exp_writes;
        is_cmd = (v.cmd == CMD_LOAD || v.cmd == CMD_FLUSH || v.cmd == CMD_EXECUTE) ? 1 : 0;
        exp_clear = (v.cmd == CMD_LOAD || v.cmd == CMD_FLUSH) ? 1 : 0;
        exp_writes = (v.cmd == CMD_LOAD && !v.full) ? int'(v.nwords) : 0;
        check_value("flush pulses", is_cmd, flushes);
        check_value("clear pulses", exp_clear, clears);
        check_value("instruction writes", exp_writes, writes);
        check_value("reports", (v.kind != 8'h00) ? 1 : 0, reports);
        if (v.kind != 8'h00)
        begin
            check_value("report kind", v.kind, last_report.kind);
            check_value("report code", v.code, last_report.code);
            if (v.code == CODE_END_PROGRAM)
            begin
                check_value("executed cycles", v.run_len, enabled_seen);
                check_value("report cycles", enabled_seen, last_report.cycles);
                check_value("cycle count", enabled_seen, o_cycle_count);
            end
            else
            begin
                check_value("report cycles", 0, last_report.cycles);
            end
        end
    endtask

    initial
    begin
        int        t, w, base;
        test_vec_t v;
        i_reset = 1'b1;
        i_rd_end = 1'b0;
        i_wr_end = 1'b0;
        i_imem_empty = 1'b0;
        i_imem_full = 1'b0;
        i_mips_end_program = 1'b0;
        i_rd_data = '0;
        read_tests();
        cycle_limit = 400 * vecs.size() + 16;
        repeat (16) step_cycle();
        i_reset = 1'b0;
        // First read request comes one cycle after reset is released.
        step_cycle();
        check_value("read start after reset", 1, o_rd_start);

        for (t = 0; t < vecs.size(); t++)
        begin
            v = vecs[t];
            cur_name = names[t];
            exp_words.delete();
            flushes = 0;
            clears = 0;
            writes = 0;
            reports = 0;
            enabled_seen = 0;
            run_len = int'(v.run_len);
            i_imem_empty = v.empty;
            i_imem_full = v.full;
            base = idle_starts;
            rx_queue.push_back(instr_t'(v.cmd));
            for (w = 0; w < int'(v.nwords); w++)
            begin
                rx_queue.push_back(v.words[w]);
                exp_words.push_back(v.words[w]);
            end
            // Done once the sequencer asks for a byte we have not queued.
            while (idle_starts == base)
                step_cycle();
            check_results(v);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: debugger_tests.txt
# name cmd nwords w0 w1 w2 w3 empty full run kind code
# cmd, words, kind and code in hex; kind 00 means no report is expected
unknown_cmd  58 0 00000000 00000000 00000000 00000000 0 0 0  45 01
flush_first  46 0 00000000 00000000 00000000 00000000 0 0 0  00 00
exec_empty   45 0 00000000 00000000 00000000 00000000 1 0 0  45 02
load_three   4c 3 20080005 2009000a ffffffff 00000000 0 0 0  49 04
exec_short   45 0 00000000 00000000 00000000 00000000 0 0 7  49 05
load_full    4c 0 00000000 00000000 00000000 00000000 0 1 0  45 03
lower_l      6c 0 00000000 00000000 00000000 00000000 0 0 0  45 01
load_halt    4c 1 ffffffff 00000000 00000000 00000000 0 0 0  49 04
exec_zero    45 0 00000000 00000000 00000000 00000000 0 0 0  49 05
load_four    4c 4 8c010000 00221820 ac030004 ffffffff 0 0 0  49 04
exec_long    45 0 00000000 00000000 00000000 00000000 0 0 45 49 05
flush_again  46 0 00000000 00000000 00000000 00000000 0 0 0  00 00
unknown_nul  00 0 00000000 00000000 00000000 00000000 0 0 0  45 01
exec_again   45 0 00000000 00000000 00000000 00000000 0 0 12 49 05
load_two     4c 2 00000000 ffffffff 00000000 00000000 0 0 0  49 04
exec_none    45 0 00000000 00000000 00000000 00000000 1 0 0  45 02

// File: filelist.f
mips_core_pkg.sv
debug_proto_pkg.sv
cycle_counter.sv
instruction_loader.sv
report_formatter.sv
debug_sequencer.sv
debugger_control.sv
debugger_control_checker.sv
tb_debugger_control.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_debugger_control -f filelist.f -o sim
	./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
